// File: src/viaPkg.sv
// shared register map, widths and bit positions for the reduced VIA, compiled before all RTL
`default_nettype none

package viaPkg;

	//////////////////////////////////////////////////
	// register map

	// 4-bit register select as seen on the bus, unlisted codes read as zero
	typedef enum logic [3:0] {
		REG_ORB   = 4'd0,  // port B output register, reads back merged pins
		REG_ORA   = 4'd1,  // port A input, clears the strobe flags on access
		REG_DDRB  = 4'd2,
		REG_DDRA  = 4'd3,
		REG_T1CL  = 4'd4,  // reading here acknowledges the timer flag
		REG_T1CH  = 4'd5,  // writing here loads and arms the counter
		REG_T1LL  = 4'd6,
		REG_T1LH  = 4'd7,
		REG_ACR   = 4'd11,
		REG_PCR   = 4'd12,
		REG_IFR   = 4'd13,
		REG_IER   = 4'd14,
		REG_ORANH = 4'd15  // same as ORA in this reduced part
	} viaReg_e;

	//////////////////////////////////////////////////
	// widths

	localparam int DATA_W = 8;   // bus and port width
	localparam int CNT_W  = 16;  // timer 1 counter and latch
	localparam int FLAG_W = 7;   // bit 7 of IFR and IER is not a real flag

	//////////////////////////////////////////////////
	// bit positions

	localparam int FLAG_CA2 = 0;  // strobe2 event
	localparam int FLAG_CA1 = 1;  // strobe1 event
	localparam int FLAG_T1  = 6;  // timer 1 expiry

	localparam int ACR_FREERUN = 6;  // set for continuous timer 1 reloads

	// a one here picks the rising edge, a zero the falling edge
	localparam int PCR_CA1POS = 0;
	localparam int PCR_CA2POS = 2;

endpackage

`default_nettype wire

// File: src/viaBusSlave.sv
// Wishbone classic slave front end of the VIA, turning bus cycles into access pulses and read data
`default_nettype none
`timescale 1ns/1ps

module viaBusSlave (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	// Wishbone classic slave side
	input  wire logic                      cyc,
	input  wire logic                      stb,
	input  wire logic                      we,
	input  wire logic [3:0]                adr,
	input  wire logic [viaPkg::DATA_W-1:0] datIn,
	output      logic [viaPkg::DATA_W-1:0] datOut,
	output      logic                      ack,
	// access towards the register stages
	output      logic                      wrPulse,
	output      logic                      rdPulse,
	output      viaPkg::viaReg_e           regSel,
	output      logic [viaPkg::DATA_W-1:0] wrData,
	// read sources
	input  wire logic [viaPkg::DATA_W-1:0] portBRd,
	input  wire logic [viaPkg::DATA_W-1:0] portAIn,
	input  wire logic [viaPkg::DATA_W-1:0] ddrB,
	input  wire logic [viaPkg::DATA_W-1:0] ddrA,
	input  wire logic [viaPkg::DATA_W-1:0] acr,
	input  wire logic [viaPkg::DATA_W-1:0] pcr,
	input  wire logic [viaPkg::CNT_W-1:0]  t1Count,
	input  wire logic [viaPkg::CNT_W-1:0]  t1Latch,
	input  wire logic [viaPkg::FLAG_W-1:0] intFlags,
	input  wire logic [viaPkg::FLAG_W-1:0] intEnable,
	input  wire logic                      irq
);
	import viaPkg::*;

	logic               req;     // new access seen this cycle
	viaReg_e            adrSel;  // live address as a register code
	logic [DATA_W-1:0]  rdByte;  // read value before this edge

	// the cycle after an ack is a dead cycle, so a held stb gets every other cycle
	assign req    = cyc & stb & ~ack;
	assign adrSel = viaReg_e'(adr);

	//////////////////////////////////////////////////
	// read multiplexer

	always_comb begin
		case (adrSel)
			REG_ORB:           rdByte = portBRd;  // pins and outputs merged upstream
			REG_ORA, REG_ORANH: rdByte = portAIn;
			REG_DDRB:          rdByte = ddrB;
			REG_DDRA:          rdByte = ddrA;
			REG_T1CL:          rdByte = t1Count[DATA_W-1:0];
			REG_T1CH:          rdByte = t1Count[CNT_W-1:DATA_W];
			REG_T1LL:          rdByte = t1Latch[DATA_W-1:0];
			REG_T1LH:          rdByte = t1Latch[CNT_W-1:DATA_W];
			REG_ACR:           rdByte = acr;
			REG_PCR:           rdByte = pcr;
			REG_IFR:           rdByte = {irq, intFlags};    // top bit shows an active request
			REG_IER:           rdByte = {1'b1, intEnable};  // top bit always reads as one
			default:           rdByte = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// handshake and capture

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			ack     <= 1'b0;
			wrPulse <= 1'b0;
			rdPulse <= 1'b0;
			regSel  <= REG_ORB;
			wrData  <= '0;
			datOut  <= '0;
		end else begin
			ack     <= req;       // one cycle after the request
			wrPulse <= req & we;  // pulses line up with ack
			rdPulse <= req & ~we;
			if (req) begin
				regSel <= adrSel;
				wrData <= datIn;
				// sample the register here so a read sees its value before the access
				if (!we)
					datOut <= rdByte;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/viaPortRegs.sv
// port B data and direction registers plus the VIA control registers, driving the port B pins
`default_nettype none
`timescale 1ns/1ps

module viaPortRegs (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	input  wire logic                      wrPulse,
	input  wire viaPkg::viaReg_e           regSel,
	input  wire logic [viaPkg::DATA_W-1:0] wrData,
	input  wire logic [viaPkg::DATA_W-1:0] portBIn,   // pin levels from the pad
	output      logic [viaPkg::DATA_W-1:0] portBOut,
	output      logic [viaPkg::DATA_W-1:0] portBOe,   // one per bit drives the pin
	output      logic [viaPkg::DATA_W-1:0] portBRd,
	output      logic [viaPkg::DATA_W-1:0] ddrB,
	output      logic [viaPkg::DATA_W-1:0] ddrA,
	output      logic [viaPkg::DATA_W-1:0] acr,
	output      logic [viaPkg::DATA_W-1:0] pcr
);
	import viaPkg::*;

	logic [DATA_W-1:0] orb;  // port B output register

	//////////////////////////////////////////////////
	// register writes

	// writes land on the edge that closes the ack cycle
	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			orb  <= '0;
			ddrB <= '0;  // all pins start as inputs
			ddrA <= '0;
			acr  <= '0;
			pcr  <= '0;
		end else if (wrPulse) begin
			case (regSel)
				REG_ORB:  orb  <= wrData;
				REG_DDRB: ddrB <= wrData;
				REG_DDRA: ddrA <= wrData;  // kept readable although port A has no drivers
				REG_ACR:  acr  <= wrData;
				REG_PCR:  pcr  <= wrData;
				default:  orb  <= orb;  // other codes belong to other stages
			endcase
		end
	end

	//////////////////////////////////////////////////
	// pin drive and readback

	assign portBOut = orb;
	assign portBOe  = ddrB;

	// output bits read the register and input bits read the pin
	assign portBRd = (orb & ddrB) | (portBIn & ~ddrB);

endmodule

`default_nettype wire

// File: src/viaTimer1.sv
// timer 1 of the VIA with its 16-bit latch, down-counter and one-shot or free-running expiry pulse
`default_nettype none
`timescale 1ns/1ps

module viaTimer1 (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	input  wire logic                      wrPulse,
	input  wire viaPkg::viaReg_e           regSel,
	input  wire logic [viaPkg::DATA_W-1:0] wrData,
	input  wire logic [viaPkg::DATA_W-1:0] acr,
	output      logic [viaPkg::CNT_W-1:0]  t1Count,
	output      logic [viaPkg::CNT_W-1:0]  t1Latch,
	output      logic                      t1Expire
);
	import viaPkg::*;

	logic armed;     // cleared after the first expiry in one-shot mode
	logic wrLo;      // low latch byte written
	logic wrHi;      // high latch byte written
	logic loadCnt;   // T1CH write starts a new count
	logic atZero;

	//////////////////////////////////////////////////
	// access decode

	assign wrLo    = wrPulse && (regSel == REG_T1CL || regSel == REG_T1LL);
	assign wrHi    = wrPulse && (regSel == REG_T1LH || regSel == REG_T1CH);
	assign loadCnt = wrPulse && (regSel == REG_T1CH);

	assign atZero = (t1Count == '0);

	// the pulse covers the cycle in which the counter sits at zero
	assign t1Expire = armed & atZero;

	//////////////////////////////////////////////////
	// latch

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			t1Latch <= '0;
		end else begin
			if (wrLo)
				t1Latch[DATA_W-1:0] <= wrData;
			if (wrHi)
				t1Latch[CNT_W-1:DATA_W] <= wrData;  // T1CH also updates the high latch
		end
	end

	//////////////////////////////////////////////////
	// counter

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			t1Count <= '0;
			armed   <= 1'b0;
		end else if (loadCnt) begin
			// new high byte comes straight from the bus, low byte from the latch
			t1Count <= {wrData, t1Latch[DATA_W-1:0]};
			armed   <= 1'b1;
		end else if (atZero) begin
			t1Count <= t1Latch;  // reload gives a period of latch+1 cycles
			if (!acr[ACR_FREERUN])
				armed <= 1'b0;  // one-shot keeps counting but stays silent
		end else begin
			t1Count <= t1Count - CNT_W'(1);
		end
	end

endmodule

`default_nettype wire

// File: src/viaStrobeEdge.sv
// synchronizes both strobe inputs and pulses on the edge that the peripheral control register picks
`default_nettype none
`timescale 1ns/1ps

module viaStrobeEdge (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	input  wire logic                      strobe1,  // asynchronous pin
	input  wire logic                      strobe2,  // asynchronous pin
	input  wire logic [viaPkg::DATA_W-1:0] pcr,
	output      logic                      edge1,
	output      logic                      edge2
);
	import viaPkg::*;

	// bit 0 carries strobe1 and bit 1 carries strobe2 throughout
	logic [1:0] syncMeta;  // first flop may go metastable
	logic [1:0] syncOut;   // settled level
	logic [1:0] prevLvl;   // level one cycle earlier
	logic [1:0] riseSel;   // one picks the rising edge
	logic [1:0] rise;
	logic [1:0] fall;
	logic [1:0] hit;

	//////////////////////////////////////////////////
	// synchronizer and history

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			syncMeta <= '0;
			syncOut  <= '0;
			prevLvl  <= '0;
		end else begin
			syncMeta <= {strobe2, strobe1};
			syncOut  <= syncMeta;
			prevLvl  <= syncOut;
		end
	end

	//////////////////////////////////////////////////
	// edge select

	assign riseSel = {pcr[PCR_CA2POS], pcr[PCR_CA1POS]};
	assign rise    = syncOut & ~prevLvl;
	assign fall    = ~syncOut & prevLvl;
	assign hit     = (riseSel & rise) | (~riseSel & fall);

	assign edge1 = hit[0];  // lasts one cycle since prevLvl catches up on the next edge
	assign edge2 = hit[1];

endmodule

`default_nettype wire

// File: src/viaIrqCtrl.sv
// interrupt flag and enable registers of the VIA and the registered active-high request output
`default_nettype none
`timescale 1ns/1ps

module viaIrqCtrl (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	input  wire logic                      wrPulse,
	input  wire logic                      rdPulse,
	input  wire viaPkg::viaReg_e           regSel,
	input  wire logic [viaPkg::DATA_W-1:0] wrData,
	input  wire logic                      t1Expire,
	input  wire logic                      edge1,
	input  wire logic                      edge2,
	output      logic [viaPkg::FLAG_W-1:0] intFlags,
	output      logic [viaPkg::FLAG_W-1:0] intEnable,
	output      logic                      irq
);
	import viaPkg::*;

	logic              portAcc;   // any access to the port A input
	logic [FLAG_W-1:0] flagSet;
	logic [FLAG_W-1:0] flagClr;
	logic [FLAG_W-1:0] bitSel;    // low bits of the written byte

	assign portAcc = (wrPulse | rdPulse) && (regSel == REG_ORA || regSel == REG_ORANH);
	assign bitSel  = wrData[FLAG_W-1:0];

	//////////////////////////////////////////////////
	// set and clear requests

	always_comb begin
		flagSet = '0;
		flagSet[FLAG_CA1] = edge1;
		flagSet[FLAG_CA2] = edge2;
		flagSet[FLAG_T1]  = t1Expire;

		flagClr = '0;
		// writing ones to IFR acknowledges those flags
		if (wrPulse && regSel == REG_IFR)
			flagClr = bitSel;
		if (portAcc) begin
			flagClr[FLAG_CA1] = 1'b1;
			flagClr[FLAG_CA2] = 1'b1;
		end
		// timer flag goes on a T1CL read or a T1CH write
		if ((rdPulse && regSel == REG_T1CL) || (wrPulse && regSel == REG_T1CH))
			flagClr[FLAG_T1] = 1'b1;
	end

	//////////////////////////////////////////////////
	// flags, enables and request

	always_ff @(posedge CA1 or posedge IFR) begin
		if (IFR) begin
			intFlags  <= '0;
			intEnable <= '0;
			irq       <= 1'b0;
		end else begin
			intFlags <= (intFlags & ~flagClr) | flagSet;  // a new event beats an acknowledge
			if (wrPulse && regSel == REG_IER) begin
				// bit 7 chooses between setting and clearing the named enables
				if (wrData[DATA_W-1])
					intEnable <= intEnable | bitSel;
				else
					intEnable <= intEnable & ~bitSel;
			end
			irq <= |(intFlags & intEnable);  // one cycle behind flags and enables
		end
	end

endmodule

`default_nettype wire

// File: src/viaTop.sv
// top level of the reduced VIA, connecting bus, register, timer, strobe and interrupt stages
`default_nettype none
`timescale 1ns/1ps

module viaTop (
	input  wire logic                      CA1,
	input  wire logic                      IFR,
	input  wire logic                      cyc,
	input  wire logic                      stb,
	input  wire logic                      we,
	input  wire logic [3:0]                adr,
	input  wire logic [viaPkg::DATA_W-1:0] datIn,
	output      logic [viaPkg::DATA_W-1:0] datOut,
	output      logic                      ack,
	input  wire logic [viaPkg::DATA_W-1:0] portAIn,
	input  wire logic [viaPkg::DATA_W-1:0] portBIn,
	output      logic [viaPkg::DATA_W-1:0] portBOut,
	output      logic [viaPkg::DATA_W-1:0] portBOe,
	input  wire logic                      strobe1,
	input  wire logic                      strobe2,
	output      logic                      irq
);
	import viaPkg::*;

	// access pulses from the bus stage
	logic              wrPulse;
	logic              rdPulse;
	viaReg_e           regSel;
	logic [DATA_W-1:0] wrData;
	// register state fed back to the read mux
	logic [DATA_W-1:0] portBRd, ddrB, ddrA, acr, pcr;
	logic [CNT_W-1:0]  t1Count, t1Latch;
	logic [FLAG_W-1:0] intFlags, intEnable;
	// events towards the interrupt stage
	logic              t1Expire, edge1, edge2;

	//////////////////////////////////////////////////
	// stages

	viaBusSlave uBus (
		.CA1(CA1), .IFR(IFR), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datIn(datIn), .datOut(datOut), .ack(ack),
		.wrPulse(wrPulse), .rdPulse(rdPulse), .regSel(regSel), .wrData(wrData),
		.portBRd(portBRd), .portAIn(portAIn), .ddrB(ddrB), .ddrA(ddrA),
		.acr(acr), .pcr(pcr), .t1Count(t1Count), .t1Latch(t1Latch),
		.intFlags(intFlags), .intEnable(intEnable), .irq(irq)
	);

	viaPortRegs uPort (
		.CA1(CA1), .IFR(IFR), .wrPulse(wrPulse), .regSel(regSel), .wrData(wrData),
		.portBIn(portBIn), .portBOut(portBOut), .portBOe(portBOe), .portBRd(portBRd),
		.ddrB(ddrB), .ddrA(ddrA), .acr(acr), .pcr(pcr)
	);

	viaTimer1 uTimer1 (
		.CA1(CA1), .IFR(IFR), .wrPulse(wrPulse), .regSel(regSel), .wrData(wrData),
		.acr(acr), .t1Count(t1Count), .t1Latch(t1Latch), .t1Expire(t1Expire)
	);

	viaStrobeEdge uStrobe (
		.CA1(CA1), .IFR(IFR), .strobe1(strobe1), .strobe2(strobe2), .pcr(pcr),
		.edge1(edge1), .edge2(edge2)
	);

	viaIrqCtrl uIrq (
		.CA1(CA1), .IFR(IFR), .wrPulse(wrPulse), .rdPulse(rdPulse), .regSel(regSel),
		.wrData(wrData), .t1Expire(t1Expire), .edge1(edge1), .edge2(edge2),
		.intFlags(intFlags), .intEnable(intEnable), .irq(irq)
	);

endmodule

`default_nettype wire

// File: tb/viaTb_assert.sv
// bus handshake and interrupt checks for the VIA, bound into viaTop and active in every simulation
`default_nettype none
`timescale 1ns/1ps

module viaTb_assert (
	input wire logic CA1,
	input wire logic IFR,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire logic irq
);

	//////////////////////////////////////////////////
	// Wishbone handshake

	// a held stb gets a dead cycle after every ack
	ackSingle: assert property (@(posedge CA1) disable iff (IFR) ack |=> !ack)
		else $error("ack stayed high for two cycles");

	ackAfterStb: assert property (@(posedge CA1) disable iff (IFR) ack |-> $past(cyc && stb))
		else $error("ack rose without an active cycle before it");  // no spurious acks

	//////////////////////////////////////////////////
	// interrupt output

	irqInReset: assert property (@(posedge CA1) IFR |-> !irq)
		else $error("irq was high while reset was asserted");

endmodule

bind viaTop viaTb_assert uAssert (
	.CA1(CA1),
	.IFR(IFR),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.irq(irq)
);

`default_nettype wire

// File: tb/viaTb.sv
// directed testbench for the reduced VIA, the simulation top that drives viaTop through its bus
`default_nettype none
`timescale 1ns/1ps

module viaTb;
	import viaPkg::*;

	localparam int CLK_PERIOD    = 4;
	localparam int RESET_CYCLES  = 3;
	localparam int ACK_WAIT      = 8;   // a healthy slave acks after one cycle
	localparam int STROBE_SETTLE = 8;   // well past the 3 to 4 cycle strobe latency
	localparam int ONESHOT_LATCH = 20;
	localparam logic [16:0] LFSR_SEED = 17'd84558;

	// cycle budgets of the tests summed for the watchdog
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 60 + 40 + 200 + 400 + 250 + 250 + 200;

	localparam logic [7:0] CA1_BIT = 8'(1 << FLAG_CA1);
	localparam logic [7:0] CA2_BIT = 8'(1 << FLAG_CA2);
	localparam logic [7:0] T1_BIT  = 8'(1 << FLAG_T1);
	localparam logic [7:0] PCR_RISE = 8'((1 << PCR_CA1POS) | (1 << PCR_CA2POS));

	logic              CA1, IFR;
	logic              cyc, stb, we;
	logic [3:0]        adr;
	logic [DATA_W-1:0] datIn, datOut;
	logic              ack, irq;
	logic [DATA_W-1:0] portAIn, portBIn, portBOut, portBOe;
	logic              strobe1, strobe2;

	logic [16:0] lfsrState;
	int          cycleCnt = 0;   // rising edges since time zero
	int          errCount = 0;
	int          checkCount = 0;

	viaTop uut (
		.CA1(CA1), .IFR(IFR), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.datIn(datIn), .datOut(datOut), .ack(ack),
		.portAIn(portAIn), .portBIn(portBIn), .portBOut(portBOut), .portBOe(portBOe),
		.strobe1(strobe1), .strobe2(strobe2), .irq(irq)
	);

	always #(CLK_PERIOD / 2) CA1 = ~CA1;

	always @(posedge CA1) cycleCnt <= cycleCnt + 1;

	//////////////////////////////////////////////////
	// helpers

	// taps x^17 + x^14 + 1 give a maximal length sequence
	function automatic logic [16:0] lfsrNext(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic randomByte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			b[i] = lfsrState[0];  // one step per bit
		end
	endtask

	task automatic idle(input int n);
		repeat (n) @(posedge CA1);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
			errCount++;
		end
	endtask

	// one Wishbone classic cycle that returns 1 ns after the ack edge
	task automatic busAccess(input logic isWrite, input viaReg_e regAddr,
			input logic [7:0] wrByte, output logic [7:0] rdByte);
		int waited;
		waited = 0;
		@(posedge CA1);
		#1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = isWrite;
		adr   = regAddr;
		datIn = wrByte;
		do begin
			@(posedge CA1);
			#1;
			waited++;
		end while (!ack && waited < ACK_WAIT);
		checkCount++;
		assert (ack) else begin
			$display("bus access to register %0d got no ack within %0d cycles",
				regAddr, ACK_WAIT);
			errCount++;
		end
		rdByte = datOut;  // valid together with ack
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
	endtask

	task automatic busWrite(input viaReg_e regAddr, input logic [7:0] data);
		logic [7:0] unused;
		busAccess(1'b1, regAddr, data, unused);
	endtask

	task automatic busRead(input viaReg_e regAddr, output logic [7:0] data);
		busAccess(1'b0, regAddr, 8'h00, data);
	endtask

	task automatic readCheck(input string name, input viaReg_e regAddr,
			input logic [7:0] expected);
		logic [7:0] got;
		busRead(regAddr, got);
		checkValue(name, expected, got);
	endtask

	// polls IFR until the flag shows and returns in seenAt the edge count at the ack of that poll
	task automatic waitFlag(input string name, input int flagPos, input int maxPolls,
			output int seenAt);
		logic [7:0] val;
		int polls;
		val   = 8'h00;
		polls = 0;
		while (!val[flagPos] && polls < maxPolls) begin
			busRead(REG_IFR, val);
			polls++;
		end
		seenAt = cycleCnt;
		checkCount++;
		assert (val[flagPos]) else begin
			$display("%s: flag bit %0d was still clear after %0d polls", name, flagPos, polls);
			errCount++;
		end
	endtask

	//////////////////////////////////////////////////
	// tests

	task automatic testRegs();
		logic [7:0] ddr, orb, acrVal, pcrVal;
		checkValue("reset irq", 8'h00, 8'(irq));
		checkValue("reset ack", 8'h00, 8'(ack));
		checkValue("reset portBOe", 8'h00, portBOe);
		randomByte(ddr);
		randomByte(orb);
		randomByte(acrVal);
		randomByte(pcrVal);
		portBIn = orb;  // pins agree with the outputs so ORB reads back whole
		busWrite(REG_DDRB, ddr);
		busWrite(REG_ORB, orb);
		busWrite(REG_ACR, acrVal);
		busWrite(REG_PCR, pcrVal);
		readCheck("regs DDRB", REG_DDRB, ddr);
		readCheck("regs ORB", REG_ORB, orb);
		readCheck("regs ACR", REG_ACR, acrVal);
		readCheck("regs PCR", REG_PCR, pcrVal);
		checkValue("regs portBOut", orb, portBOut);
		checkValue("regs portBOe", ddr, portBOe);
	endtask

	task automatic testPortRead();
		logic [7:0] ddr, orb, pins, aIn, merged;
		randomByte(ddr);
		randomByte(orb);
		randomByte(pins);
		randomByte(aIn);
		portBIn = pins;
		portAIn = aIn;
		// a driven bit reads its output register and an input bit reads its pin
		for (int i = 0; i < 8; i++)
			merged[i] = ddr[i] ? orb[i] : pins[i];
		busWrite(REG_DDRB, ddr);
		busWrite(REG_ORB, orb);
		readCheck("port B merge", REG_ORB, merged);
		readCheck("port A", REG_ORA, aIn);
		readCheck("port A no handshake", REG_ORANH, aIn);
	endtask

	task automatic testOneShot();
		logic [7:0] got;
		int loadCycle, seenAt, elapsed;
		busWrite(REG_ACR, 8'h00);
		busWrite(REG_T1LL, 8'(ONESHOT_LATCH));
		busWrite(REG_T1CH, 8'(ONESHOT_LATCH >> 8));
		loadCycle = cycleCnt + 1;  // counter loads on the edge that closes the ack cycle
		waitFlag("oneShot", FLAG_T1, ONESHOT_LATCH + 4, seenAt);
		elapsed = seenAt - 1 - loadCycle;  // the poll saw flags from the cycle before its ack
		checkCount++;
		assert (elapsed >= ONESHOT_LATCH + 1) else begin
			$display("mismatch oneShot set time: expected at least %0d cycles, got %0d",
				ONESHOT_LATCH + 1, elapsed);
			errCount++;
		end
		busRead(REG_T1CL, got);
		idle(2 * (ONESHOT_LATCH + 1));
		readCheck("oneShot stays clear", REG_IFR, 8'h00);
	endtask

	task automatic testFreeRun();
		logic [7:0] lo, got;
		int period, seenAt;
		randomByte(lo);
		lo = 8'h10 | (lo & 8'h0F);  // keeps the period between 17 and 32 cycles
		period = int'(lo) + 1;
		busWrite(REG_ACR, 8'(1 << ACR_FREERUN));
		busWrite(REG_T1LL, lo);
		busWrite(REG_T1LH, 8'h00);
		readCheck("freeRun latch low", REG_T1LL, lo);
		readCheck("freeRun latch high", REG_T1LH, 8'h00);
		busWrite(REG_T1CH, 8'h00);
		waitFlag("freeRun first", FLAG_T1, period + 4, seenAt);
		busRead(REG_T1CL, got);
		waitFlag("freeRun again", FLAG_T1, period + 4, seenAt);
		// back in one-shot the counter goes silent after at most one more expiry
		busWrite(REG_ACR, 8'h00);
		idle(2 * period);
		busWrite(REG_IFR, 8'h7F);
		idle(2 * period);
		readCheck("freeRun stopped", REG_IFR, 8'h00);
	endtask

	task automatic testStrobes();
		logic [7:0] got;
		int seenAt;
		busWrite(REG_IFR, 8'h7F);
		busWrite(REG_PCR, PCR_RISE);
		strobe1 = 1'b1;
		waitFlag("strobe1 rising", FLAG_CA1, STROBE_SETTLE, seenAt);
		readCheck("strobe1 rising only", REG_IFR, CA1_BIT);
		busWrite(REG_IFR, CA1_BIT);
		readCheck("strobe IFR clear", REG_IFR, 8'h00);
		strobe1 = 1'b0;
		idle(STROBE_SETTLE);
		readCheck("strobe1 falling ignored", REG_IFR, 8'h00);
		busWrite(REG_PCR, 8'h00);  // both strobes now on the falling edge
		strobe1 = 1'b1;
		idle(STROBE_SETTLE);
		readCheck("strobe1 rising ignored", REG_IFR, 8'h00);
		strobe1 = 1'b0;
		waitFlag("strobe1 falling", FLAG_CA1, STROBE_SETTLE, seenAt);
		strobe2 = 1'b1;
		idle(STROBE_SETTLE);
		readCheck("strobe2 rising ignored", REG_IFR, CA1_BIT);
		strobe2 = 1'b0;
		waitFlag("strobe2 falling", FLAG_CA2, STROBE_SETTLE, seenAt);
		readCheck("strobe both flags", REG_IFR, CA1_BIT | CA2_BIT);
		busRead(REG_ORA, got);
		checkValue("strobe ORA data", portAIn, got);
		readCheck("strobe ORA clears", REG_IFR, 8'h00);
	endtask

	task automatic testIrq();
		logic [7:0] got;
		int seenAt;
		busWrite(REG_IFR, 8'h7F);
		readCheck("irq IER reset", REG_IER, 8'h80);
		busWrite(REG_IER, 8'h80 | CA1_BIT);
		readCheck("irq IER set", REG_IER, 8'h80 | CA1_BIT);
		busWrite(REG_PCR, PCR_RISE);
		strobe2 = 1'b1;  // CA2 is not enabled yet
		waitFlag("irq strobe2", FLAG_CA2, STROBE_SETTLE, seenAt);
		idle(2);
		checkValue("irq masked", 8'h00, 8'(irq));
		readCheck("irq masked IFR", REG_IFR, CA2_BIT);
		strobe1 = 1'b1;
		waitFlag("irq strobe1", FLAG_CA1, STROBE_SETTLE, seenAt);
		idle(2);
		checkValue("irq enabled", 8'h01, 8'(irq));
		readCheck("irq enabled IFR", REG_IFR, 8'h80 | CA1_BIT | CA2_BIT);
		busWrite(REG_IER, CA1_BIT);  // bit 7 low clears the named enable
		readCheck("irq IER clear", REG_IER, 8'h80);
		idle(2);
		checkValue("irq after clear", 8'h00, 8'(irq));
		readCheck("irq after clear IFR", REG_IFR, CA1_BIT | CA2_BIT);
		busWrite(REG_IER, 8'h80 | T1_BIT | CA2_BIT);
		readCheck("irq IER set two", REG_IER, 8'h80 | T1_BIT | CA2_BIT);
		idle(2);
		checkValue("irq from CA2", 8'h01, 8'(irq));
		readCheck("irq from CA2 IFR", REG_IFR, 8'h80 | CA1_BIT | CA2_BIT);
		busWrite(REG_IFR, CA2_BIT);
		idle(2);
		checkValue("irq CA2 acknowledged", 8'h00, 8'(irq));
		readCheck("irq CA2 acknowledged IFR", REG_IFR, CA1_BIT);
		busWrite(REG_T1LL, 8'h08);
		busWrite(REG_T1CH, 8'h00);
		waitFlag("irq timer", FLAG_T1, 12, seenAt);
		idle(2);
		checkValue("irq from timer", 8'h01, 8'(irq));
		readCheck("irq from timer IFR", REG_IFR, 8'h80 | T1_BIT | CA1_BIT);
		busRead(REG_T1CL, got);
		idle(2);
		checkValue("irq timer acknowledged", 8'h00, 8'(irq));
		readCheck("irq timer acknowledged IFR", REG_IFR, CA1_BIT);
		strobe1 = 1'b0;  // falling edges are ignored while PCR picks rising
		strobe2 = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// sequence and watchdog

	initial begin
		CA1       = 1'b0;
		IFR       = 1'b1;
		cyc       = 1'b0;
		stb       = 1'b0;
		we        = 1'b0;
		adr       = 4'h0;
		datIn     = 8'h00;
		portAIn   = 8'h00;
		portBIn   = 8'h00;
		strobe1   = 1'b0;
		strobe2   = 1'b0;
		lfsrState = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge CA1);
		#1;
		IFR = 1'b0;
		testRegs();
		testPortRead();
		testOneShot();
		testFreeRun();
		testStrobes();
		testIrq();
		$display("checks run: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("checks run: %0d, errors: %0d", checkCount, errCount);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
src/viaPkg.sv
src/viaBusSlave.sv
src/viaPortRegs.sv
src/viaTimer1.sv
src/viaStrobeEdge.sv
src/viaIrqCtrl.sv
src/viaTop.sv
tb/viaTb_assert.sv
tb/viaTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the VIA testbench with Verilator, runs it and checks the log for the fail message.

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module viaTb -Mdir "$BUILD_DIR" -o viaSim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/viaSim" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG_FILE"; then
	exit 1
fi
exit 0
